// File: common/led_pkg.sv
package led_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Panel geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_CHAINS      = 4;
  localparam int WORD_BITS       = 16;
  localparam int WORDS_PER_CHAIN = 8;
  localparam int CHAIN_BITS      = WORDS_PER_CHAIN * WORD_BITS;
  localparam int SEL_BITS        = 2;

  // Derived counter widths
  localparam int WORD_IDX_BITS = $clog2(WORDS_PER_CHAIN);
  localparam int BIT_IDX_BITS  = $clog2(WORD_BITS);
  localparam int FILL_BITS     = $clog2(CHAIN_BITS) + 1;
  localparam int DIV_BITS      = 8;
  localparam int ERR_BITS      = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADR_BITS = 8;
  localparam int DAT_BITS = 32;

  localparam logic [ADR_BITS-1:0] ADR_CTRL       = 8'h00;
  localparam logic [ADR_BITS-1:0] ADR_STATUS     = 8'h01;
  localparam logic [ADR_BITS-1:0] ADR_FRAME_BASE = 8'h40;

  // Frame words follow the base, chain major
  localparam int FRAME_WORDS = NUM_CHAINS * WORDS_PER_CHAIN;

  // Control register bit positions
  localparam int CTRL_START     = 0;
  localparam int CTRL_CLEAR_ERR = 1;
  localparam int CTRL_SEL_LSB   = 2;
  localparam int CTRL_GCLK_EN   = 4;
  localparam int CTRL_DIV_LSB   = 8;

  // Status register bit positions
  localparam int STAT_BUSY    = 0;
  localparam int STAT_PRIMED  = 1;
  localparam int STAT_ERR_LSB = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Bus and scan types
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [ADR_BITS-1:0] adr;
    logic [DAT_BITS-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [DAT_BITS-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic                start;
    logic                clear_err;
    logic [SEL_BITS-1:0] chain_sel;
    logic                gclk_en;
    logic [DIV_BITS-1:0] gclk_div;
  } ctrl_t;

  typedef logic [WORD_BITS-1:0] pixel_word_t;

  // One word index across every chain, lane n is chain n
  typedef pixel_word_t [NUM_CHAINS-1:0] frame_row_t;

  typedef struct packed {
    logic load;
    logic shift;
    logic sclk;
  } shift_ctrl_t;

endpackage

// File: rtl/wb_frame_port.sv
module wb_frame_port (
  input  logic                                clock_33,
  input  logic                                nrst,
  input  led_pkg::wb_req_t                    wb_req,
  output led_pkg::wb_rsp_t                    wb_rsp,
  output led_pkg::ctrl_t                      ctrl,
  input  logic [led_pkg::WORD_IDX_BITS-1:0]   row_idx,
  output led_pkg::frame_row_t                 row,
  input  logic                                busy,
  input  logic                                primed,
  input  logic [led_pkg::ERR_BITS-1:0]        err_count
);

  led_pkg::frame_row_t frame_mem [led_pkg::WORDS_PER_CHAIN];

  led_pkg::ctrl_t                       ctrl_q;
  logic                                 ack_q;
  logic [led_pkg::DAT_BITS-1:0]         dat_q;
  logic [led_pkg::DAT_BITS-1:0]         rd_data;
  logic                                 req;
  logic                                 wr;
  logic [led_pkg::ADR_BITS-1:0]         frame_off;
  logic                                 is_frame;
  logic [led_pkg::SEL_BITS-1:0]         acc_chain;
  logic [led_pkg::WORD_IDX_BITS-1:0]    acc_word;

  // New request only while no ack is out, so each access acks once
  assign req = wb_req.cyc & wb_req.stb & ~ack_q;
  assign wr  = req & wb_req.we;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign frame_off = wb_req.adr - led_pkg::ADR_FRAME_BASE;
  assign is_frame  = (wb_req.adr >= led_pkg::ADR_FRAME_BASE) &&
                     (frame_off < led_pkg::FRAME_WORDS);

  // Offset splits into chain (upper) and word within chain (lower)
  assign acc_word  = frame_off[led_pkg::WORD_IDX_BITS-1:0];
  assign acc_chain = frame_off[led_pkg::WORD_IDX_BITS +: led_pkg::SEL_BITS];

  always_comb begin
    rd_data = '0;
    if (wb_req.adr == led_pkg::ADR_CTRL) begin
      rd_data[led_pkg::CTRL_SEL_LSB +: led_pkg::SEL_BITS] = ctrl_q.chain_sel;
      rd_data[led_pkg::CTRL_GCLK_EN]                      = ctrl_q.gclk_en;
      rd_data[led_pkg::CTRL_DIV_LSB +: led_pkg::DIV_BITS] = ctrl_q.gclk_div;
    end else if (wb_req.adr == led_pkg::ADR_STATUS) begin
      rd_data[led_pkg::STAT_BUSY]                         = busy;
      rd_data[led_pkg::STAT_PRIMED]                       = primed;
      rd_data[led_pkg::STAT_ERR_LSB +: led_pkg::ERR_BITS] = err_count;
    end else if (is_frame) begin
      rd_data[led_pkg::WORD_BITS-1:0] = frame_mem[acc_word][acc_chain];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and control register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      ack_q  <= 1'b0;
      ctrl_q <= '0;
    end else begin
      ack_q            <= req;
      // Strobes last one cycle
      ctrl_q.start     <= 1'b0;
      ctrl_q.clear_err <= 1'b0;
      if (wr && wb_req.adr == led_pkg::ADR_CTRL) begin
        ctrl_q.start     <= wb_req.dat[led_pkg::CTRL_START];
        ctrl_q.clear_err <= wb_req.dat[led_pkg::CTRL_CLEAR_ERR];
        ctrl_q.chain_sel <= wb_req.dat[led_pkg::CTRL_SEL_LSB +: led_pkg::SEL_BITS];
        ctrl_q.gclk_en   <= wb_req.dat[led_pkg::CTRL_GCLK_EN];
        ctrl_q.gclk_div  <= wb_req.dat[led_pkg::CTRL_DIV_LSB +: led_pkg::DIV_BITS];
      end
    end
  end

  // Frame memory, lane write per chain and scanner fetch port
  always_ff @(posedge clock_33) begin
    if (req) begin
      dat_q <= rd_data;
    end
    if (wr && is_frame) begin
      frame_mem[acc_word][acc_chain] <= wb_req.dat[led_pkg::WORD_BITS-1:0];
    end
    row <= frame_mem[row_idx];
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;
  assign ctrl       = ctrl_q;

endmodule

// File: rtl/gclk_gen.sv
module gclk_gen (
  input  logic           clock_33,
  input  logic           nrst,
  input  led_pkg::ctrl_t ctrl,
  output logic           gclk
);

  logic [led_pkg::DIV_BITS-1:0] div_cnt;
  logic                         gclk_q;

  ////////////////////////////////////////////////////////////////////////////
  // Divider
  ////////////////////////////////////////////////////////////////////////////

  // Half period is gclk_div+1 cycles
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      div_cnt <= '0;
      gclk_q  <= 1'b0;
    end else if (!ctrl.gclk_en) begin
      // Parked low, next enable starts a fresh half period
      div_cnt <= '0;
      gclk_q  <= 1'b0;
    end else if (div_cnt == ctrl.gclk_div) begin
      div_cnt <= '0;
      gclk_q  <= ~gclk_q;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign gclk = gclk_q;

endmodule

// File: scan/frame_scanner.sv
module frame_scanner (
  input  logic                              clock_33,
  input  logic                              nrst,
  input  led_pkg::ctrl_t                    ctrl,
  output logic [led_pkg::WORD_IDX_BITS-1:0] row_idx,
  output led_pkg::shift_ctrl_t              shift,
  output logic                              lat,
  output logic                              busy
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_LOAD,
    ST_SHIFT,
    ST_LATCH
  } state_t;

  state_t                            state;
  logic [led_pkg::WORD_IDX_BITS-1:0] word_cnt;
  logic [led_pkg::BIT_IDX_BITS-1:0]  bit_cnt;
  // Low half then high half of each bit period
  logic                              phase;

  ////////////////////////////////////////////////////////////////////////////
  // Word and bit sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      state    <= ST_IDLE;
      word_cnt <= '0;
      bit_cnt  <= '0;
      phase    <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // start while busy never reaches here
          if (ctrl.start) begin
            word_cnt <= '0;
            state    <= ST_FETCH;
          end
        end
        ST_FETCH: state <= ST_LOAD;
        ST_LOAD: begin
          bit_cnt <= '0;
          phase   <= 1'b0;
          state   <= ST_SHIFT;
        end
        ST_SHIFT: begin
          phase <= ~phase;
          if (phase) begin
            if (bit_cnt == led_pkg::BIT_IDX_BITS'(led_pkg::WORD_BITS - 1)) begin
              state <= ST_LATCH;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        ST_LATCH: begin
          if (word_cnt == led_pkg::WORD_IDX_BITS'(led_pkg::WORDS_PER_CHAIN - 1)) begin
            state <= ST_IDLE;
          end else begin
            word_cnt <= word_cnt + 1'b1;
            state    <= ST_FETCH;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // Memory answers this index one cycle later, in time for load
  assign row_idx = word_cnt;

  assign shift.load  = (state == ST_LOAD);
  assign shift.sclk  = (state == ST_SHIFT) && phase;
  // Shifters advance on the edge that drops sclk
  assign shift.shift = (state == ST_SHIFT) && phase;

  assign lat  = (state == ST_LATCH);
  assign busy = (state != ST_IDLE);

endmodule

// File: scan/chain_shifter.sv
module chain_shifter (
  input  logic                 clock_33,
  input  logic                 nrst,
  input  led_pkg::shift_ctrl_t shift,
  input  led_pkg::pixel_word_t word,
  output logic                 sin
);

  led_pkg::pixel_word_t word_q;

  ////////////////////////////////////////////////////////////////////////////
  // Word register, MSB first
  ////////////////////////////////////////////////////////////////////////////

  // Cleared so the data line idles low
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      word_q <= '0;
    end else if (shift.load) begin
      word_q <= word;
    end else if (shift.shift) begin
      word_q <= {word_q[led_pkg::WORD_BITS-2:0], 1'b0};
    end
  end

  // Straight from the flop, so stable across the whole sclk high cycle
  assign sin = word_q[led_pkg::WORD_BITS-1];

endmodule

// File: scan/readback_checker.sv
module readback_checker (
  input  logic                           clock_33,
  input  logic                           nrst,
  input  led_pkg::ctrl_t                 ctrl,
  input  led_pkg::shift_ctrl_t           shift,
  input  logic [led_pkg::NUM_CHAINS-1:0] sin,
  input  logic                           sout,
  output logic                           primed,
  output logic [led_pkg::ERR_BITS-1:0]   err_count
);

  logic [led_pkg::CHAIN_BITS-2:0] hist;
  logic [led_pkg::CHAIN_BITS-1:0] window;
  logic [led_pkg::SEL_BITS-1:0]   sel_q;
  logic [led_pkg::FILL_BITS-1:0]  fill_cnt;
  logic                           sel_changed;
  logic                           mismatch;

  ////////////////////////////////////////////////////////////////////////////
  // History of the selected chain
  ////////////////////////////////////////////////////////////////////////////

  // Last CHAIN_BITS bits sent, the one clocked in this cycle at the bottom.
  // By the end of the sclk high cycle the chain has taken that bit, so
  // sout shows the oldest bit of this window
  assign window = {hist, sin[ctrl.chain_sel]};

  always_ff @(posedge clock_33) begin
    if (shift.sclk) begin
      hist <= window[led_pkg::CHAIN_BITS-2:0];
    end
  end

  assign sel_changed = (ctrl.chain_sel != sel_q);
  assign primed      = (fill_cnt == led_pkg::FILL_BITS'(led_pkg::CHAIN_BITS));

  // Fill count toward one full chain, restarted on a new selection
  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      sel_q    <= '0;
      fill_cnt <= '0;
    end else if (sel_changed) begin
      sel_q    <= ctrl.chain_sel;
      fill_cnt <= '0;
    end else if (shift.sclk && !primed) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare and count
  ////////////////////////////////////////////////////////////////////////////

  assign mismatch = shift.sclk && primed && !sel_changed &&
                    (sout != window[led_pkg::CHAIN_BITS-1]);

  always_ff @(posedge clock_33) begin
    if (!nrst) begin
      err_count <= '0;
    end else if (ctrl.clear_err) begin
      err_count <= '0;
    end else if (mismatch && err_count != '1) begin
      err_count <= err_count + 1'b1;
    end
  end

endmodule

// File: rtl/led_panel_top.sv
module led_panel_top (
  input  logic                           clock_33,
  input  logic                           nrst,
  input  led_pkg::wb_req_t               wb_req,
  output led_pkg::wb_rsp_t               wb_rsp,
  output logic [led_pkg::NUM_CHAINS-1:0] sin,
  output logic                           sclk,
  output logic                           lat,
  output logic                           gclk,
  input  logic                           sout,
  output logic [led_pkg::SEL_BITS-1:0]   sout_mux
);

  led_pkg::ctrl_t                    ctrl;
  led_pkg::frame_row_t               row;
  led_pkg::shift_ctrl_t              shift;
  logic [led_pkg::WORD_IDX_BITS-1:0] row_idx;
  logic                              busy;
  logic                              primed;
  logic [led_pkg::ERR_BITS-1:0]      err_count;

  ////////////////////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////////////////////

  wb_frame_port wb_frame_port_i (
    .clock_33  (clock_33),
    .nrst      (nrst),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .ctrl      (ctrl),
    .row_idx   (row_idx),
    .row       (row),
    .busy      (busy),
    .primed    (primed),
    .err_count (err_count)
  );

  gclk_gen gclk_gen_i (
    .clock_33 (clock_33),
    .nrst     (nrst),
    .ctrl     (ctrl),
    .gclk     (gclk)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Scan path
  ////////////////////////////////////////////////////////////////////////////

  frame_scanner frame_scanner_i (
    .clock_33 (clock_33),
    .nrst     (nrst),
    .ctrl     (ctrl),
    .row_idx  (row_idx),
    .shift    (shift),
    .lat      (lat),
    .busy     (busy)
  );

  for (genvar g = 0; g < led_pkg::NUM_CHAINS; g++) begin : g_chain
    chain_shifter chain_shifter_i (
      .clock_33 (clock_33),
      .nrst     (nrst),
      .shift    (shift),
      .word     (row[g]),
      .sin      (sin[g])
    );
  end

  readback_checker readback_checker_i (
    .clock_33  (clock_33),
    .nrst      (nrst),
    .ctrl      (ctrl),
    .shift     (shift),
    .sin       (sin),
    .sout      (sout),
    .primed    (primed),
    .err_count (err_count)
  );

  assign sclk     = shift.sclk;
  // Board mux routes the selected chain's end back to sout
  assign sout_mux = ctrl.chain_sel;

endmodule

// File: testbench/tb_led_panel.sv
module tb_led_panel;

  localparam int REC_WORDS    = led_pkg::FRAME_WORDS + 2;
  localparam int NUM_RECS     = 3;
  localparam int NUM_FRAMES   = 12;
  localparam int NUM_ACCESSES = 1500;
  // Frames times 280 plus 2000 per access, with a margin of 4
  localparam int WATCHDOG_CYCLES = (NUM_FRAMES * 280 + NUM_ACCESSES * 2000) * 4;

  logic                           clock_33;
  logic                           nrst;
  led_pkg::wb_req_t               wb_req;
  led_pkg::wb_rsp_t               wb_rsp;
  logic [led_pkg::NUM_CHAINS-1:0] sin;
  logic                           sclk;
  logic                           lat;
  logic                           gclk;
  logic                           sout;
  logic [led_pkg::SEL_BITS-1:0]   sout_mux;

  logic [31:0]                    vec [NUM_RECS*REC_WORDS];
  logic [led_pkg::CHAIN_BITS-1:0] chain_model [led_pkg::NUM_CHAINS];
  logic [led_pkg::CHAIN_BITS-1:0] cap [led_pkg::NUM_CHAINS];
  logic [led_pkg::CHAIN_BITS-1:0] flip_mask;
  logic                           inject;
  logic [31:0]                    rng;
  logic [31:0]                    ctrl_reg;
  int bit_idx = 0;
  int lat_cnt = 0;
  int checks = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_bad = 0;
  int test_err_base = 0;

  led_panel_top led_panel_top_i (
    .clock_33 (clock_33),
    .nrst     (nrst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .sin      (sin),
    .sclk     (sclk),
    .lat      (lat),
    .gclk     (gclk),
    .sout     (sout),
    .sout_mux (sout_mux)
  );

  initial clock_33 = 1'b0;
  always #50 clock_33 = ~clock_33;

  ////////////////////////////////////////////////////////////////////////////
  // Driver chain model
  ////////////////////////////////////////////////////////////////////////////

  // Drivers sample sin on sclk rising and sout shows the oldest bit
  always @(posedge sclk) begin
    for (int c = 0; c < led_pkg::NUM_CHAINS; c++) begin
      cap[c][bit_idx] = sin[c];
      chain_model[c]  = {chain_model[c][led_pkg::CHAIN_BITS-2:0], sin[c]};
    end
    sout <= chain_model[sout_mux][led_pkg::CHAIN_BITS-1] ^ (inject & flip_mask[bit_idx]);
    bit_idx = (bit_idx + 1) % led_pkg::CHAIN_BITS;
  end

  always @(negedge clock_33) begin
    if (lat) begin
      lat_cnt++;
    end
  end

  initial begin
    #(longint'(WATCHDOG_CYCLES) * 100);
    $display("Watchdog expired, the DUT stopped responding");
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Control register layout as the bus sees it
  function automatic led_pkg::ctrl_t reg_to_ctrl(input logic [31:0] r);
    led_pkg::ctrl_t c;
    c.start     = r[0];
    c.clear_err = r[1];
    c.chain_sel = r[3:2];
    c.gclk_en   = r[4];
    c.gclk_div  = r[15:8];
    return c;
  endfunction

  task automatic check_word(input string name, input led_pkg::pixel_word_t exp,
                            input led_pkg::pixel_word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_ctrl(input string name, input led_pkg::ctrl_t exp,
                            input led_pkg::ctrl_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_err_base) begin
      $display("%-12s ok", name);
    end else begin
      tests_bad++;
      $display("%-12s FAIL, %0d mismatches", name, errors - test_err_base);
    end
    test_err_base = errors;
  endtask

  task automatic bus_write(input logic [7:0] adr, input logic [31:0] dat);
    @(posedge clock_33);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    do @(negedge clock_33); while (!wb_rsp.ack);
    @(posedge clock_33);
    wb_req <= '0;
  endtask

  task automatic bus_read(input logic [7:0] adr, output logic [31:0] dat);
    @(posedge clock_33);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    do @(negedge clock_33); while (!wb_rsp.ack);
    dat = wb_rsp.dat;
    @(posedge clock_33);
    wb_req <= '0;
  endtask

  task automatic read_status(output logic busy, output logic primed,
                             output logic [15:0] err);
    logic [31:0] r;
    bus_read(led_pkg::ADR_STATUS, r);
    busy   = r[0];
    primed = r[1];
    err    = r[31:16];
  endtask

  task automatic load_frame(input int rec);
    for (int i = 0; i < led_pkg::FRAME_WORDS; i++) begin
      bus_write(8'(led_pkg::ADR_FRAME_BASE + i), vec[rec*REC_WORDS+i]);
    end
  endtask

  // Start a frame and poll status until busy drops
  task automatic run_frame(output int lats);
    int          lat0;
    logic        busy;
    logic        primed;
    logic [15:0] err;
    lat0 = lat_cnt;
    bus_write(led_pkg::ADR_CTRL, ctrl_reg | 32'h1);
    do read_status(busy, primed, err); while (busy);
    lats = lat_cnt - lat0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] cw;
    logic        busy_s;
    logic        primed_s;
    logic [15:0] err_s;
    logic [15:0] word;
    longint      t0;
    int          period;
    int          highs;
    int          lats;
    int          div;
    int          k;
    int          n;
    int          pos;

    wb_req    = '0;
    sout      = 1'b0;
    nrst      = 1'b0;
    inject    = 1'b0;
    flip_mask = '0;
    rng       = 32'h1b93;
    ctrl_reg  = 32'h0;
    for (int c = 0; c < led_pkg::NUM_CHAINS; c++) begin
      chain_model[c] = '0;
      cap[c]         = '0;
    end
    $readmemh("testbench/led_vectors.txt", vec);
    repeat (3) @(posedge clock_33);
    nrst <= 1'b1;
    @(negedge clock_33);

    check_count("reset_pins", 16'h0, 16'({sclk, lat, gclk, sin}));
    read_status(busy_s, primed_s, err_s);
    check_count("reset_status", 16'h0, 16'({busy_s, primed_s}) | err_s);
    finish_test("reset");

    // Start and clear_err are write strobes and read back as 0
    cw = vec[led_pkg::FRAME_WORDS];
    bus_write(led_pkg::ADR_CTRL, cw | 32'h2);
    bus_read(led_pkg::ADR_CTRL, rd);
    check_ctrl("ctrl_readback", reg_to_ctrl(cw & 32'hffff_fffc), reg_to_ctrl(rd));
    check_count("sout_mux", 16'(cw[3:2]), 16'(sout_mux));
    load_frame(0);
    for (int i = 0; i < led_pkg::FRAME_WORDS; i++) begin
      bus_read(8'(led_pkg::ADR_FRAME_BASE + i), rd);
      check_word($sformatf("frame_rd_%0d", i), vec[i][15:0], rd[15:0]);
    end
    finish_test("registers");

    for (int r = 0; r < NUM_RECS; r++) begin
      load_frame(r);
      ctrl_reg = vec[r*REC_WORDS+led_pkg::FRAME_WORDS] & 32'hffff_ffec;
      run_frame(lats);
      check_count($sformatf("lat_pulses_%0d", r), 16'(led_pkg::WORDS_PER_CHAIN), 16'(lats));
      // Written with start set, reads back with start clear
      bus_read(led_pkg::ADR_CTRL, rd);
      check_ctrl($sformatf("ctrl_start_%0d", r), reg_to_ctrl(ctrl_reg), reg_to_ctrl(rd));
      for (int c = 0; c < led_pkg::NUM_CHAINS; c++) begin
        for (int w = 0; w < led_pkg::WORDS_PER_CHAIN; w++) begin
          // First captured bit is the MSB
          for (int b = 0; b < led_pkg::WORD_BITS; b++) begin
            word[15-b] = cap[c][w*led_pkg::WORD_BITS+b];
          end
          check_word($sformatf("shift_r%0d_c%0d_w%0d", r, c, w),
                     vec[r*REC_WORDS+c*led_pkg::WORDS_PER_CHAIN+w][15:0], word);
        end
      end
    end
    finish_test("frame_shift");

    for (int r = 0; r < NUM_RECS; r++) begin
      cw  = (vec[r*REC_WORDS+led_pkg::FRAME_WORDS] & 32'hffff_fffc) | 32'h10;
      div = int'(cw[15:8]);
      bus_write(led_pkg::ADR_CTRL, cw);
      @(posedge gclk);
      t0 = longint'($time);
      @(posedge gclk);
      period = int'((longint'($time) - t0) / 100);
      check_count($sformatf("gclk_period_%0d", r), 16'(2 * (div + 1)), 16'(period));
      bus_write(led_pkg::ADR_CTRL, cw & 32'hffff_ffef);
      @(posedge clock_33);
      highs = 0;
      repeat (2 * (div + 1) + 4) begin
        @(negedge clock_33);
        if (gclk) begin
          highs++;
        end
      end
      check_count($sformatf("gclk_parked_%0d", r), 16'h0, 16'(highs));
    end
    finish_test("gclk");

    load_frame(1);
    ctrl_reg = vec[REC_WORDS+led_pkg::FRAME_WORDS] & 32'hffff_ffec;
    run_frame(lats);
    run_frame(lats);
    read_status(busy_s, primed_s, err_s);
    check_count("loop_primed", 16'h1, 16'(primed_s));
    check_count("loop_errors", 16'h0, err_s);
    // New chain selection restarts the fill
    ctrl_reg = ctrl_reg ^ 32'h4;
    bus_write(led_pkg::ADR_CTRL, ctrl_reg);
    read_status(busy_s, primed_s, err_s);
    check_count("resel_unprimed", 16'h0, 16'(primed_s));
    run_frame(lats);
    read_status(busy_s, primed_s, err_s);
    check_count("resel_primed", 16'h1, 16'(primed_s));
    check_count("resel_errors", 16'h0, err_s);
    finish_test("loopback");

    for (int r = 0; r < NUM_RECS; r++) begin
      load_frame(r);
      ctrl_reg = vec[r*REC_WORDS+led_pkg::FRAME_WORDS] & 32'hffff_ffec;
      bus_write(led_pkg::ADR_CTRL, ctrl_reg | 32'h2);
      run_frame(lats);
      read_status(busy_s, primed_s, err_s);
      check_count($sformatf("fault_primed_%0d", r), 16'h1, 16'(primed_s));
      check_count($sformatf("fault_clean_%0d", r), 16'h0, err_s);
      k = int'(vec[r*REC_WORDS+led_pkg::FRAME_WORDS+1]);
      flip_mask = '0;
      n = 0;
      while (n < k) begin
        rng = xorshift(rng);
        pos = int'(rng % 32'd128);
        if (!flip_mask[pos]) begin
          flip_mask[pos] = 1'b1;
          n++;
        end
      end
      inject = 1'b1;
      run_frame(lats);
      inject = 1'b0;
      read_status(busy_s, primed_s, err_s);
      check_count($sformatf("fault_count_%0d", r), 16'(k), err_s);
      bus_write(led_pkg::ADR_CTRL, ctrl_reg | 32'h2);
      read_status(busy_s, primed_s, err_s);
      check_count($sformatf("fault_cleared_%0d", r), 16'h0, err_s);
    end
    finish_test("faults");

    $display("Tests: %0d run, %0d with mismatches; checks: %0d run, %0d mismatched",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: testbench/led_vectors.txt
// Per test: four lines of eight frame words (chain 0 to 3, word 0 to 7),
// then the control register value and the number of inverted sout bits
// test 0
a5f0 1234 ffff 0000 8001 7ffe 0f0f f0f0
c3a5 5a3c 0001 8000 dead beef 4321 1357
2468 9bdf aaaa 5555 cafe f00d 0ff0 3c3c
7e81 1818 e7e7 abcd ef01 2345 6789 fedc
00000314 00000003
// test 1
0102 0304 0506 0708 090a 0b0c 0d0e 0f10
1111 2222 3333 4444 5555 6666 7777 8888
9999 aaaa bbbb cccc dddd eeee ffff 0000
f00f 0ff0 a0a0 0a0a 5050 0505 c0c0 0c0c
0000000c 00000000
// test 2
ffff fffe fffd fffb fff7 ffef ffdf ffbf
0001 0002 0004 0008 0010 0020 0040 0080
1f2e 3d4c 5b6a 7988 97a6 b5c4 d3e2 f100
6b3a 29f8 e7d6 c5b4 a392 8170 5f4e 3d2c
00000918 00000007

// File: tb.f
common/led_pkg.sv
rtl/wb_frame_port.sv
rtl/gclk_gen.sv
scan/frame_scanner.sv
scan/chain_shifter.sv
scan/readback_checker.sv
rtl/led_panel_top.sv
testbench/tb_led_panel.sv

// File: Makefile
SRCS := $(shell grep -v '^+' tb.f)

.PHONY: all run clean

all: obj_dir/Vtb_led_panel

obj_dir/Vtb_led_panel: tb.f $(SRCS)
	verilator --binary -j 0 --top-module tb_led_panel -f tb.f -o Vtb_led_panel

run: obj_dir/Vtb_led_panel testbench/led_vectors.txt
	./obj_dir/Vtb_led_panel | tee /dev/stderr | grep -q "^All tests passed$$"

clean:
	rm -rf obj_dir
